// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fp_cmp_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# pass or fail comes from the log, not the simulator exit code
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^Verification passed$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/fp_classify.sv ====
// combinational; expects the word after box substitution, so singles are taken as boxed
`timescale 1ns/1ps

module fp_classify (
    input  fp_types_pkg::fp_operand_u operand_i,
    input  fp_types_pkg::fp_fmt_e     fmt_i,
    output fp_types_pkg::fp_class_t   class_o
);
    import fp_types_pkg::*;

    logic sign;
    logic exp_zero;
    logic exp_ones;
    logic man_zero;
    logic man_top;  // quiet bit for NaNs

    // pick the fields of the active format
    always_comb begin
        if (fmt_i == FP_FMT_D) begin
            sign     = operand_i.d.sign;
            exp_zero = (operand_i.d.exp == '0);
            exp_ones = &operand_i.d.exp;
            man_zero = (operand_i.d.man == '0);
            man_top  = operand_i.d.man[`FP_D_MAN_W-1];
        end else begin
            sign     = operand_i.s.sign;
            exp_zero = (operand_i.s.exp == '0);
            exp_ones = &operand_i.s.exp;
            man_zero = (operand_i.s.man == '0);
            man_top  = operand_i.s.man[`FP_S_MAN_W-1];
        end
    end

    // exactly one bit set
    always_comb begin
        class_o = '0;

        if (exp_ones) begin
            if (man_zero) begin
                class_o[sign ? CLS_NEG_INF : CLS_POS_INF] = 1'b1;
            end else if (man_top) begin
                class_o[CLS_QNAN] = 1'b1;
            end else begin
                class_o[CLS_SNAN] = 1'b1;  // NaN sign is ignored
            end
        end else if (exp_zero) begin
            if (man_zero) begin
                class_o[sign ? CLS_NEG_ZERO : CLS_POS_ZERO] = 1'b1;
            end else begin
                class_o[sign ? CLS_NEG_SUB : CLS_POS_SUB] = 1'b1;
            end
        end else begin
            class_o[sign ? CLS_NEG_NORM : CLS_POS_NORM] = 1'b1;
        end
    end

endmodule

// ==== hw/fp_cmp.sv ====
// combinational FLE/FLT/FEQ; operands must come from fp_extend, only NV is ever raised
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_cmp (
    input  fp_types_pkg::fp_cmp_op_e op_i,
    input  logic [`FP_EXT_W-1:0]     data1_i,
    input  logic [`FP_EXT_W-1:0]     data2_i,
    input  fp_types_pkg::fp_class_t  class1_i,
    input  fp_types_pkg::fp_class_t  class2_i,
    output logic [`FP_XLEN-1:0]      result_o,
    output logic [`FP_FLAGS_W-1:0]   flags_o
);
    import fp_types_pkg::*;

    logic [`FP_XLEN-1:0] mag1;
    logic [`FP_XLEN-1:0] mag2;
    logic                sign1;
    logic                sign2;
    logic                mag_lt;
    logic                mag_le;
    logic                any_snan;
    logic                any_nan;
    logic                both_zero;  // +0 and -0 are the same value

    assign sign1 = data1_i[`FP_EXT_W-1];
    assign sign2 = data2_i[`FP_EXT_W-1];
    assign mag1  = data1_i[`FP_XLEN-1:0];
    assign mag2  = data2_i[`FP_XLEN-1:0];

    assign mag_lt = (mag1 < mag2);
    assign mag_le = (mag1 <= mag2);

    assign any_snan  = class1_i[CLS_SNAN] | class2_i[CLS_SNAN];
    assign any_nan   = any_snan | class1_i[CLS_QNAN] | class2_i[CLS_QNAN];
    assign both_zero = (class1_i[CLS_NEG_ZERO] | class1_i[CLS_POS_ZERO])
                     & (class2_i[CLS_NEG_ZERO] | class2_i[CLS_POS_ZERO]);

    always_comb begin
        result_o = '0;
        flags_o  = '0;

        case (op_i)
            FP_CMP_FEQ: begin
                if (any_snan) begin
                    flags_o[`FP_NV_BIT] = 1'b1;  // quiet compare, signalling only
                end else if (any_nan) begin
                    result_o[0] = 1'b0;
                end else if (both_zero) begin
                    result_o[0] = 1'b1;
                end else begin
                    result_o[0] = (data1_i == data2_i);
                end
            end

            FP_CMP_FLT: begin
                if (any_nan) begin
                    flags_o[`FP_NV_BIT] = 1'b1;
                end else if (both_zero) begin
                    result_o[0] = 1'b0;
                end else if (sign1 != sign2) begin
                    result_o[0] = sign1;  // negative one is smaller
                end else if (sign1) begin
                    result_o[0] = ~mag_le;  // order flips for negatives
                end else begin
                    result_o[0] = mag_lt;
                end
            end

            FP_CMP_FLE: begin
                if (any_nan) begin
                    flags_o[`FP_NV_BIT] = 1'b1;
                end else if (both_zero) begin
                    result_o[0] = 1'b1;
                end else if (sign1 != sign2) begin
                    result_o[0] = sign1;
                end else if (sign1) begin
                    result_o[0] = ~mag_lt;
                end else begin
                    result_o[0] = mag_le;
                end
            end

            default: begin
                result_o = '0;  // unused op codes
                flags_o  = '0;
            end
        endcase
    end

endmodule

// ==== hw/fp_cmp_unit.sv ====
// two-cycle fixed latency, one op per cycle, no back-pressure; outputs read zero when valid_o is low
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_cmp_unit (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       valid_i,
    input  fp_types_pkg::fp_cmp_op_e   op_i,
    input  fp_types_pkg::fp_fmt_e      fmt_i,
    input  logic [`FP_XLEN-1:0]        src1_i,
    input  logic [`FP_XLEN-1:0]        src2_i,
    output logic                       valid_o,
    output logic [`FP_XLEN-1:0]        result_o,
    output logic [`FP_FLAGS_W-1:0]     flags_o
);
    import fp_types_pkg::*;

    fp_operand_u           op1_word;
    fp_operand_u           op2_word;
    fp_operand_u           op1_sub;  // after box substitution
    fp_operand_u           op2_sub;
    logic [`FP_EXT_W-1:0]  ext1;
    logic [`FP_EXT_W-1:0]  ext2;
    fp_class_t             class1;
    fp_class_t             class2;

    // stage 1
    logic                  s1_valid;
    fp_cmp_op_e            s1_op;
    logic [`FP_EXT_W-1:0]  s1_ext1;
    logic [`FP_EXT_W-1:0]  s1_ext2;
    fp_class_t             s1_class1;
    fp_class_t             s1_class2;

    logic [`FP_XLEN-1:0]    cmp_result;
    logic [`FP_FLAGS_W-1:0] cmp_flags;

    assign op1_word = fp_operand_u'(src1_i);
    assign op2_word = fp_operand_u'(src2_i);

    fp_extend   u_ext1 (.operand_i(op1_word), .fmt_i(fmt_i), .ext_o(ext1), .word_o(op1_sub));
    fp_extend   u_ext2 (.operand_i(op2_word), .fmt_i(fmt_i), .ext_o(ext2), .word_o(op2_sub));
    fp_classify u_cls1 (.operand_i(op1_sub), .fmt_i(fmt_i), .class_o(class1));
    fp_classify u_cls2 (.operand_i(op2_sub), .fmt_i(fmt_i), .class_o(class2));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= valid_i;
        end

        if (valid_i) begin  // payload only moves with a valid op
            s1_op     <= op_i;
            s1_ext1   <= ext1;
            s1_ext2   <= ext2;
            s1_class1 <= class1;
            s1_class2 <= class2;
        end
    end

    fp_cmp u_cmp (
        .op_i     (s1_op),
        .data1_i  (s1_ext1),
        .data2_i  (s1_ext2),
        .class1_i (s1_class1),
        .class2_i (s1_class2),
        .result_o (cmp_result),
        .flags_o  (cmp_flags)
    );

    // stage 2, zero unless stage 1 holds a valid op
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_o  <= 1'b0;
            result_o <= '0;
            flags_o  <= '0;
        end else begin
            valid_o  <= s1_valid;
            result_o <= s1_valid ? cmp_result : '0;
            flags_o  <= s1_valid ? cmp_flags : '0;
        end
    end

endmodule

// ==== hw/fp_extend.sv ====
// combinational; an unboxed single is replaced by the canonical quiet NaN before anything else
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_extend (
    input  fp_types_pkg::fp_operand_u operand_i,
    input  fp_types_pkg::fp_fmt_e     fmt_i,
    output logic [`FP_EXT_W-1:0]      ext_o,
    output fp_types_pkg::fp_operand_u word_o
);
    import fp_types_pkg::*;

    // canonical quiet single NaN, already boxed
    localparam logic [`FP_XLEN-1:0] S_QNAN_BOXED = 64'hffff_ffff_7fc0_0000;

    // zeros between the single sign and its 31 magnitude bits
    localparam int S_PAD_W = `FP_EXT_W - 1 - `FP_S_EXP_W - `FP_S_MAN_W;

    logic boxed;

    assign boxed = &operand_i.s.box;

    always_comb begin
        word_o = operand_i;
        ext_o  = '0;

        if (fmt_i == FP_FMT_D) begin
            // sign on top, word with its sign cleared below
            ext_o = {operand_i.d.sign,
                     1'b0,
                     operand_i.d.exp,
                     operand_i.d.man};
        end else begin
            if (!boxed) begin
                word_o = S_QNAN_BOXED;  // broken box reads as qNaN
            end

            // magnitude zero-extended, so unsigned compare orders same-sign values
            ext_o = {word_o.s.sign,
                     {S_PAD_W{1'b0}},
                     word_o.s.exp,
                     word_o.s.man};
        end
    end

endmodule

// ==== hw/fp_types_pkg.sv ====
// types for the compare path only; single view assumes the box sits in the upper 32 bits
`include "fpu_config.svh"

package fp_types_pkg;

    // double view of a register word
    typedef struct packed {
        logic                   sign;
        logic [`FP_D_EXP_W-1:0] exp;
        logic [`FP_D_MAN_W-1:0] man;
    } fp_double_t;

    // boxed single view, box must be all ones
    typedef struct packed {
        logic [`FP_XLEN-`FP_S_EXP_W-`FP_S_MAN_W-2:0] box;
        logic                                        sign;
        logic [`FP_S_EXP_W-1:0]                      exp;
        logic [`FP_S_MAN_W-1:0]                      man;
    } fp_single_t;

    typedef union packed {
        fp_double_t d;
        fp_single_t s;
    } fp_operand_u;

    // one-hot class vector, riscv fclass bit order
    typedef logic [`FP_CLASS_W-1:0] fp_class_t;

    localparam int CLS_NEG_INF  = 0;
    localparam int CLS_NEG_NORM = 1;
    localparam int CLS_NEG_SUB  = 2;
    localparam int CLS_NEG_ZERO = 3;
    localparam int CLS_POS_ZERO = 4;
    localparam int CLS_POS_SUB  = 5;
    localparam int CLS_POS_NORM = 6;
    localparam int CLS_POS_INF  = 7;
    localparam int CLS_SNAN     = 8;
    localparam int CLS_QNAN     = 9;

    typedef enum logic [2:0] {
        FP_CMP_FLE = 3'd0,
        FP_CMP_FLT = 3'd1,
        FP_CMP_FEQ = 3'd2  // 3..7 unused, give zero
    } fp_cmp_op_e;

    typedef enum logic {
        FP_FMT_S = 1'b0,
        FP_FMT_D = 1'b1
    } fp_fmt_e;

endpackage

// ==== hw/fpu_config.svh ====
// assumes RV64 with F and D; singles live NaN-boxed in the low half of a 64-bit register
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// register and datapath widths
`define FP_XLEN     64
`define FP_EXT_W    65  // sign plus 64 magnitude bits
`define FP_CLASS_W  10  // fclass order
`define FP_FLAGS_W  5   // NV DZ OF UF NX
`define FP_NV_BIT   4

// single precision fields
`define FP_S_EXP_W  8
`define FP_S_MAN_W  23

// double precision fields
`define FP_D_EXP_W  11
`define FP_D_MAN_W  52

`endif

// ==== tb.f ====
+incdir+hw
hw/fp_types_pkg.sv
hw/fp_extend.sv
hw/fp_classify.sv
hw/fp_cmp.sv
hw/fp_cmp_unit.sv
test/fp_cmp_sva.sv
test/fp_cmp_tb.sv

// ==== test/fp_cmp_sva.sv ====
// bound to fp_cmp_unit; NV is the top flag bit and valid_i stays low while reset is held
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_cmp_sva (
    input logic                   clk,
    input logic                   reset_i,
    input logic                   valid_i,
    input logic                   valid_o,
    input logic [`FP_XLEN-1:0]    result_o,
    input logic [`FP_FLAGS_W-1:0] flags_o
);
    a_latency: assert property (@(posedge clk) disable iff (reset_i)
        valid_o == $past(valid_i, 2)) else $error("valid_o not two cycles after valid_i");

    a_reset_low: assert property (@(posedge clk) reset_i |=> !valid_o)
        else $error("valid_o high after reset");

    a_result_shape: assert property (@(posedge clk) disable iff (reset_i)
        result_o[`FP_XLEN-1:1] == '0) else $error("result_o upper bits set");

    a_flag_shape: assert property (@(posedge clk) disable iff (reset_i)
        flags_o[`FP_NV_BIT-1:0] == '0) else $error("flag other than NV raised");  // only NV

    a_idle_zero: assert property (@(posedge clk) disable iff (reset_i)
        !valid_o |-> (result_o == '0 && flags_o == '0)) else $error("outputs not zero when idle");

endmodule

bind fp_cmp_unit fp_cmp_sva u_sva (
    .clk(clk), .reset_i(reset_i), .valid_i(valid_i),
    .valid_o(valid_o), .result_o(result_o), .flags_o(flags_o)
);

// ==== test/fp_cmp_tb.sv ====
// stimulus is single-threaded and held low in reset; latency checks assume no back-pressure
`timescale 1ns/1ps
`include "fpu_config.svh"

module fp_cmp_tb;
    import fp_types_pkg::*;

    typedef enum int {K_RAND, K_SPEC, K_ZERO, K_NAN, K_UNBOX, K_INF} kind_e;

    localparam int RESET_CYC   = 16;
    localparam int N_ORDER     = 400;
    localparam int N_ZERO      = 32;
    localparam int N_NAN       = 200;
    localparam int N_BOX       = 150;
    localparam int N_INF       = 120;
    localparam int N_UNUSED    = 60;
    localparam int N_THRU      = 300;
    localparam int TOTAL_OPS   = N_ORDER + N_ZERO + N_NAN + N_BOX + N_INF + N_UNUSED + N_THRU;
    localparam int TIMEOUT_CYC = RESET_CYC + 2 * TOTAL_OPS + 7 * 4 + 50;  // op plus one gap each

    // +0 -0 +inf -inf qnan snan -qnan -snan +sub -sub +max -max +1 -1 +minnorm -2
    localparam logic [63:0] D_SPECIAL [16] = '{
        64'h0000_0000_0000_0000, 64'h8000_0000_0000_0000, 64'h7ff0_0000_0000_0000,
        64'hfff0_0000_0000_0000, 64'h7ff8_0000_0000_0000, 64'h7ff0_0000_0000_0001,
        64'hfff8_0000_0000_0000, 64'hfff4_0000_0000_0000, 64'h0000_0000_0000_0001,
        64'h800f_ffff_ffff_ffff, 64'h7fef_ffff_ffff_ffff, 64'hffef_ffff_ffff_ffff,
        64'h3ff0_0000_0000_0000, 64'hbff0_0000_0000_0000, 64'h0010_0000_0000_0000,
        64'hc000_0000_0000_0000};
    localparam logic [31:0] S_SPECIAL [16] = '{
        32'h0000_0000, 32'h8000_0000, 32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000,
        32'h7f80_0001, 32'hffc0_0000, 32'hffa0_0000, 32'h0000_0001, 32'h807f_ffff,
        32'h7f7f_ffff, 32'hff7f_ffff, 32'h3f80_0000, 32'hbf80_0000, 32'h0080_0000,
        32'hc000_0000};

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   valid_i;
    fp_cmp_op_e             op_i;
    fp_fmt_e                fmt_i;
    logic [`FP_XLEN-1:0]    src1_i;
    logic [`FP_XLEN-1:0]    src2_i;
    logic                   valid_o;
    logic [`FP_XLEN-1:0]    result_o;
    logic [`FP_FLAGS_W-1:0] flags_o;

    logic [31:0]            lfsr = 32'h180f_3afe;
    logic [63:0]            res_q [$];
    logic [4:0]             flg_q [$];
    int                     cyc_q [$];  // edge that sampled each op
    int                     cycle_cnt = 0;
    int                     errors = 0;
    int                     checks = 0;
    int                     ntests = 0;
    string                  test_name = "reset";

    fp_cmp_unit dut (
        .clk(clk), .reset_i(reset_i), .valid_i(valid_i), .op_i(op_i), .fmt_i(fmt_i),
        .src1_i(src1_i), .src2_i(src2_i), .valid_o(valid_o), .result_o(result_o),
        .flags_o(flags_o)
    );

    always #20 clk = ~clk;

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);  // x^32+x^22+x^2+x+1
            v = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [63:0] gen_word(input logic is_d, input kind_e kind);
        logic [63:0] r;
        logic [3:0]  idx;
        r = rand_bits(64);
        case (kind)
            K_ZERO:  idx = {3'b000, r[0]};
            K_NAN:   idx = {2'b01, r[1:0]};
            K_INF:   idx = {3'b001, r[0]};
            default: idx = r[3:0];
        endcase
        if (kind == K_RAND) return is_d ? r : {32'hffff_ffff, r[31:0]};
        if (kind == K_UNBOX) return {r[63:32] & ~(32'h1 << r[4:0]), r[31:0]};  // box has a hole
        return is_d ? D_SPECIAL[idx] : {32'hffff_ffff, S_SPECIAL[idx]};
    endfunction

    // maps every non-NaN value to a signed key in IEEE order with -0 and +0 both at 0
    function automatic void decode(input logic is_d, input logic [63:0] w, output logic nan,
                                   output logic snan, output logic signed [65:0] key);
        logic [63:0] v;
        logic        sign;
        logic [62:0] mag;
        v = w;
        if (is_d) begin
            sign = v[63];
            mag  = v[62:0];
            nan  = (v[62:52] == 11'h7ff) && (v[51:0] != 52'd0);
            snan = nan && !v[51];
        end else begin
            if (v[63:32] != 32'hffff_ffff) v = 64'hffff_ffff_7fc0_0000;
            sign = v[31];
            mag  = {32'd0, v[30:0]};
            nan  = (v[30:23] == 8'hff) && (v[22:0] != 23'd0);
            snan = nan && !v[22];
        end
        key = sign ? -$signed({3'b000, mag}) : $signed({3'b000, mag});
    endfunction

    // returns {flags, result bit}
    function automatic logic [5:0] model(input logic [2:0] op, input logic is_d,
                                         input logic [63:0] a, input logic [63:0] b);
        logic               nan1;
        logic               nan2;
        logic               snan1;
        logic               snan2;
        logic signed [65:0] k1;
        logic signed [65:0] k2;
        logic [4:0]         nv;
        nv = 5'd1 << `FP_NV_BIT;
        decode(is_d, a, nan1, snan1, k1);
        decode(is_d, b, nan2, snan2, k2);
        case (op)
            3'd0:    return (nan1 | nan2) ? {nv, 1'b0} : {5'd0, k1 <= k2};
            3'd1:    return (nan1 | nan2) ? {nv, 1'b0} : {5'd0, k1 < k2};
            3'd2:    return (snan1 | snan2) ? {nv, 1'b0} : {5'd0, !(nan1 | nan2) && k1 == k2};
            default: return 6'd0;
        endcase
    endfunction

    task automatic check(input string what, input logic [63:0] expected,
                         input logic [63:0] actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("Error: %s %s expected %h actual %h", test_name, what, expected, actual);
        end
    endtask

    task automatic issue(input logic [2:0] op, input logic is_d, input logic [63:0] a,
                         input logic [63:0] b);
        logic [5:0] m;
        @(posedge clk);
        #1;
        valid_i = 1'b1;
        op_i    = fp_cmp_op_e'(op);
        fmt_i   = fp_fmt_e'(is_d);
        src1_i  = a;
        src2_i  = b;
        m = model(op, is_d, a, b);
        res_q.push_back({63'd0, m[0]});
        flg_q.push_back(m[5:1]);
        cyc_q.push_back(cycle_cnt + 1);
    endtask

    task automatic idle();
        @(posedge clk);
        #1;
        valid_i = 1'b0;
    endtask

    task automatic run_test(input string name, input int n, input kind_e k1, input kind_e k2,
                            input logic unused_ops, input logic gaps);
        int          start_err;
        logic [63:0] r;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] t;
        logic        is_d;
        logic [2:0]  op;
        test_name = name;
        start_err = errors;
        for (int i = 0; i < n; i++) begin
            r = rand_bits(8);
            is_d = (k1 == K_UNBOX || k2 == K_UNBOX) ? 1'b0 : r[0];
            op = unused_ops ? r[3:1] : ((r[2:1] == 2'b11) ? 3'd2 : {1'b0, r[2:1]});
            if (unused_ops && op < 3'd3) op = op + 3'd3;
            a = gen_word(is_d, k1);
            b = (r[5:4] == 2'b00) ? a : gen_word(is_d, k2);  // equal pair now and then
            if (r[6]) begin
                t = a;
                a = b;
                b = t;
            end
            issue(op, is_d, a, b);
            if (gaps && r[7]) idle();
        end
        idle();
        while (res_q.size() != 0) @(posedge clk);
        ntests++;
        $display("test %-10s %0d ops, %0d errors", name, n, errors - start_err);
    endtask

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout after %0d cycles with %0d results outstanding", cycle_cnt,
                     res_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        if (!reset_i && valid_o) begin
            if (res_q.size() == 0) begin
                errors++;
                $display("valid_o pulse with no operation outstanding in test %s", test_name);
            end else begin
                check("result", res_q.pop_front(), result_o);
                check("flags", {59'd0, flg_q.pop_front()}, {59'd0, flags_o});
                // the next rising edge is the one that samples valid_o
                check("latency", 64'd2, 64'(cycle_cnt + 1 - cyc_q.pop_front()));
            end
        end
    end

    initial begin
        reset_i = 1'b1;
        valid_i = 1'b0;
        op_i    = FP_CMP_FLE;
        fmt_i   = FP_FMT_S;
        src1_i  = '0;
        src2_i  = '0;
        repeat (RESET_CYC) @(posedge clk);
        #1;
        reset_i = 1'b0;

        run_test("ordering", N_ORDER, K_RAND, K_RAND, 1'b0, 1'b0);
        run_test("zeros", N_ZERO, K_ZERO, K_ZERO, 1'b0, 1'b0);
        run_test("nan", N_NAN, K_NAN, K_SPEC, 1'b0, 1'b0);
        run_test("boxing", N_BOX, K_UNBOX, K_SPEC, 1'b0, 1'b0);
        run_test("infinity", N_INF, K_INF, K_SPEC, 1'b0, 1'b0);
        run_test("unused_op", N_UNUSED, K_SPEC, K_RAND, 1'b1, 1'b0);
        run_test("throughput", N_THRU, K_SPEC, K_RAND, 1'b0, 1'b1);

        $display("summary: %0d tests, %0d checks, %0d errors", ntests, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
